//--- mips_lite.f
+incdir+verilog
+incdir+tb
verilog/mips_lite_pkg.sv
verilog/ex_if.sv
verilog/apb_instr_port.sv
verilog/decode_issue.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mips_lite_top.sv
tb/tb_mips_lite.sv

//--- tb/tb_mips_lite_ref.svh
// reference model of the register file, instruction results and retired count
`ifndef TB_MIPS_LITE_REF_SVH
`define TB_MIPS_LITE_REF_SVH

logic [`MIPS_DATA_W-1:0] model_regs [0:`MIPS_NUM_REGS-1];
logic [`MIPS_DATA_W-1:0] exp_retired;

// expected destination value of one instruction, do_write is low when nothing is written
function automatic logic [`MIPS_DATA_W-1:0] ref_result(
    input  logic [`MIPS_DATA_W-1:0] instr,
    output logic                    do_write,
    output logic [`MIPS_REG_W-1:0]  dest
);
    logic [`MIPS_DATA_W-1:0] a;
    logic [`MIPS_DATA_W-1:0] b;
    logic [`MIPS_DATA_W-1:0] simm;
    logic [`MIPS_DATA_W-1:0] zimm;
    logic [`MIPS_DATA_W-1:0] res;
    a        = model_regs[instr[25:21]];
    b        = model_regs[instr[20:16]];
    simm     = {{16{instr[15]}}, instr[15:0]};
    zimm     = {16'h0000, instr[15:0]};
    res      = '0;
    do_write = 1'b1;
    dest     = instr[20:16];
    case (instr[31:26])
        mips_lite_pkg::SPECIAL: begin
            dest = instr[15:11];
            case (instr[5:0])
                mips_lite_pkg::SLL:  res = b << instr[10:6];
                mips_lite_pkg::SRL:  res = b >> instr[10:6];
                mips_lite_pkg::ADDU: res = a + b;
                mips_lite_pkg::SUBU: res = a - b;
                mips_lite_pkg::AND:  res = a & b;
                mips_lite_pkg::OR:   res = a | b;
                mips_lite_pkg::XOR:  res = a ^ b;
                mips_lite_pkg::NOR:  res = ~(a | b);
                mips_lite_pkg::SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:             do_write = 1'b0;
            endcase
        end
        mips_lite_pkg::ADDIU: res = a + simm;
        mips_lite_pkg::SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        mips_lite_pkg::ANDI:  res = a & zimm;
        mips_lite_pkg::ORI:   res = a | zimm;
        mips_lite_pkg::XORI:  res = a ^ zimm;
        mips_lite_pkg::LUI:   res = {instr[15:0], 16'h0000};
        default:              do_write = 1'b0;
    endcase
    // register 0 is hardwired
    if (dest == '0) begin
        do_write = 1'b0;
    end
    return res;
endfunction

// every instruction retires, written or not
function automatic void model_apply(input logic [`MIPS_DATA_W-1:0] instr);
    logic                    do_write;
    logic [`MIPS_REG_W-1:0]  dest;
    logic [`MIPS_DATA_W-1:0] res;
    res = ref_result(instr, do_write, dest);
    if (do_write) begin
        model_regs[dest] = res;
    end
    exp_retired = exp_retired + 1;
endfunction

function automatic void model_reset();
    for (int n = 0; n < `MIPS_NUM_REGS; n++) begin
        model_regs[n] = '0;
    end
    exp_retired = '0;
endfunction

`endif

//--- tb/tb_mips_lite.sv
// testbench for mips_lite_top with APB tasks, stimulus, compare process and compare tasks
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module tb_mips_lite;

    localparam int WAIT_LIMIT = 100;

    logic                          clk;
    logic                          arst_n;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`MIPS_APB_ADDR_W-1:0]   paddr;
    logic [`MIPS_DATA_W-1:0]       pwdata;
    logic [`MIPS_DATA_W-1:0]       prdata;
    logic                          pready;
    logic                          pslverr;
    integer                        seed;

    // observed results waiting for the compare process
    string                   word_name_q [$];
    logic [`MIPS_DATA_W-1:0] word_exp_q [$];
    logic [`MIPS_DATA_W-1:0] word_act_q [$];
    string                   resp_name_q [$];
    logic                    resp_exp_q [$];
    logic                    resp_act_q [$];

    `include "tb_mips_lite_ref.svh"

    mips_lite_top u_mips_lite_top (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [`MIPS_DATA_W-1:0] exp_val,
                                input logic [`MIPS_DATA_W-1:0] act_val);
        if (act_val !== exp_val) begin
            report_failure($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp_val, act_val));
        end
    endtask

    task automatic compare_resp(input string name, input logic exp_err, input logic act_err);
        if (act_err !== exp_err) begin
            report_failure($sformatf("FAIL %s pslverr expected 0x%h got 0x%h",
                                     name, exp_err, act_err));
        end
    endtask

    // results are pushed just after a rising edge and have settled by the falling edge
    always @(negedge clk) begin
        while (word_exp_q.size() > 0) begin
            compare_word(word_name_q.pop_front(), word_exp_q.pop_front(),
                         word_act_q.pop_front());
        end
        while (resp_exp_q.size() > 0) begin
            compare_resp(resp_name_q.pop_front(), resp_exp_q.pop_front(),
                         resp_act_q.pop_front());
        end
    end

    // pready is sampled mid-cycle and the transfer completes on the next rising edge
    task automatic wait_ready(output int waits);
        waits = 0;
        @(negedge clk);
        while (!pready && waits < WAIT_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            report_failure("APB access phase timed out without pready");
        end
    endtask

    task automatic apb_write(input logic [`MIPS_APB_ADDR_W-1:0] addr,
                             input logic [`MIPS_DATA_W-1:0] data, input logic exp_err);
        logic err;
        int   waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        wait_ready(waits);
        // a write never stalls and completes in its first access cycle
        if (waits != 0) begin
            report_failure("APB write was not ready in its first access cycle");
        end
        err = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        resp_name_q.push_back($sformatf("write 0x%h", addr));
        resp_exp_q.push_back(exp_err);
        resp_act_q.push_back(err);
    endtask

    task automatic apb_read(input logic [`MIPS_APB_ADDR_W-1:0] addr,
                            input logic [`MIPS_DATA_W-1:0] exp_data, input logic exp_err,
                            input string name);
        logic                    err;
        logic [`MIPS_DATA_W-1:0] data;
        int                      waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        wait_ready(waits);
        err  = pslverr;
        data = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        word_name_q.push_back(name);
        word_exp_q.push_back(exp_data);
        word_act_q.push_back(data);
        resp_name_q.push_back(name);
        resp_exp_q.push_back(exp_err);
        resp_act_q.push_back(err);
    endtask

    task automatic issue(input logic [`MIPS_DATA_W-1:0] instr);
        apb_write(`MIPS_ADDR_INSTR, instr, 1'b0);
        model_apply(instr);
    endtask

    task automatic check_reg(input int n);
        apb_read(`MIPS_ADDR_REG_BASE + 12'(n * 4), model_regs[n], 1'b0,
                 $sformatf("reg[%0d]", n));
    endtask

    task automatic check_all_regs();
        for (int n = 0; n < `MIPS_NUM_REGS; n++) begin
            check_reg(n);
        end
    endtask

    task automatic check_retired();
        apb_read(`MIPS_ADDR_RETIRED, exp_retired, 1'b0, "retired");
    endtask

    function automatic logic [`MIPS_DATA_W-1:0] r_instr(input mips_lite_pkg::funct_e f,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
        input logic [4:0] shamt);
        return {mips_lite_pkg::SPECIAL, rs, rt, rd, shamt, f};
    endfunction

    function automatic logic [`MIPS_DATA_W-1:0] i_instr(input mips_lite_pkg::opcode_e op,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_lite_pkg::funct_e pick_funct(input int k);
        case (k)
            0:       return mips_lite_pkg::SLL;
            1:       return mips_lite_pkg::SRL;
            2:       return mips_lite_pkg::ADDU;
            3:       return mips_lite_pkg::SUBU;
            4:       return mips_lite_pkg::AND;
            5:       return mips_lite_pkg::OR;
            6:       return mips_lite_pkg::XOR;
            7:       return mips_lite_pkg::NOR;
            default: return mips_lite_pkg::SLT;
        endcase
    endfunction

    initial begin
        logic [`MIPS_DATA_W-1:0] rnd;
        logic [4:0]              rs;
        logic [4:0]              rt;
        logic [4:0]              rd;
        logic [4:0]              prev_rd;
        mips_lite_pkg::opcode_e  op;
        int                      cycles;
        seed    = 61076;
        clk     = 1'b0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;

        check_all_regs();
        check_retired();

        // immediate loads go to random destinations and every eighth one aims at register 0
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            rt  = (i % 8 == 0) ? 5'd0 : rnd[20:16];
            case (rnd % 3)
                0:       op = mips_lite_pkg::ADDIU;
                1:       op = mips_lite_pkg::ORI;
                default: op = mips_lite_pkg::LUI;
            endcase
            issue(i_instr(op, rnd[25:21], rt, rnd[15:0]));
            check_reg(rt);
            check_reg(0);
        end

        // in back-to-back chains the previous rd feeds rs or rt through the bypass
        prev_rd = 5'd1;
        for (int i = 0; i < 45; i++) begin
            rnd = $random(seed);
            rd  = rnd[15:11];
            if (i % 2 == 0) begin
                issue(r_instr(pick_funct(i % 9), prev_rd, rnd[20:16], rd, rnd[10:6]));
            end else begin
                issue(r_instr(pick_funct(i % 9), rnd[25:21], prev_rd, rd, rnd[10:6]));
            end
            prev_rd = rd;
        end
        check_all_regs();
        check_retired();

        // negative SLTI immediates and zero-extended ANDI and XORI
        issue(i_instr(mips_lite_pkg::ADDIU, 5'd0, 5'd5, 16'hFF00));
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            rs  = (i < 6) ? 5'd5 : rnd[25:21];
            rt  = (rnd[20:16] == 5'd0) ? 5'd7 : rnd[20:16];
            case (i % 3)
                0:       op = mips_lite_pkg::SLTI;
                1:       op = mips_lite_pkg::ANDI;
                default: op = mips_lite_pkg::XORI;
            endcase
            issue(i_instr(op, rs, rt, {1'b1, rnd[14:0]}));
            check_reg(rt);
        end

        // unknown opcode and unknown funct retire without a write
        rnd = $random(seed);
        issue({6'h3F, rnd[25:0]});
        issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3F});
        check_all_regs();
        check_retired();

        // error responses leave the state alone
        apb_write(`MIPS_ADDR_RETIRED, 32'hDEAD_BEEF, 1'b1);
        apb_write(12'h200, rnd, 1'b1);
        apb_read(`MIPS_ADDR_INSTR, '0, 1'b1, "instruction port read");
        apb_read(12'h040, '0, 1'b1, "unmapped read");
        apb_read(`MIPS_ADDR_REG_BASE + 12'h001, '0, 1'b1, "misaligned register read");
        check_all_regs();
        check_retired();

        cycles = 0;
        while ((word_exp_q.size() + resp_exp_q.size()) > 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if ((word_exp_q.size() + resp_exp_q.size()) > 0) begin
            report_failure("compare queues still hold results at the end of the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- verilog/apb_instr_port.sv
// apb_instr_port module: APB slave, instruction register, issue counter and read mux
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module apb_instr_port (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`MIPS_APB_ADDR_W-1:0]   paddr_i,
    input  logic [`MIPS_DATA_W-1:0]       pwdata_i,
    output logic [`MIPS_DATA_W-1:0]       prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic                          instr_valid_o,
    output logic [`MIPS_DATA_W-1:0]       instr_o,
    input  logic [`MIPS_DATA_W-1:0]       retired_i,
    output logic [`MIPS_REG_W-1:0]        host_idx_o,
    input  logic [`MIPS_DATA_W-1:0]       host_data_i
);

    logic                          access;
    logic                          addr_instr;
    logic                          addr_retired;
    logic                          addr_reg;
    logic                          rd_mapped;
    logic                          pipe_empty;
    logic                          instr_wr;
    logic [`MIPS_APB_ADDR_W-1:0]   reg_off;
    logic [`MIPS_DATA_W-1:0]       instr_q;
    logic [`MIPS_DATA_W-1:0]       issue_cnt_q;
    logic                          instr_valid_q;

    assign access = psel_i & penable_i;

    // address map decode
    assign reg_off      = paddr_i - `MIPS_ADDR_REG_BASE;
    assign addr_instr   = (paddr_i == `MIPS_ADDR_INSTR);
    assign addr_retired = (paddr_i == `MIPS_ADDR_RETIRED);
    assign addr_reg     = (paddr_i >= `MIPS_ADDR_REG_BASE) &&
                          (reg_off < (`MIPS_NUM_REGS * 4)) &&
                          (paddr_i[1:0] == 2'b00);
    assign rd_mapped    = addr_retired | addr_reg;
    assign host_idx_o   = reg_off[`MIPS_REG_W+1:2];

    // every issued instruction has retired, so register state is final
    assign pipe_empty = (issue_cnt_q == retired_i);

    // writes and bad reads finish at once, mapped reads wait for the pipeline
    assign pready_o  = access & (pwrite_i | ~rd_mapped | pipe_empty);
    assign pslverr_o = access & (pwrite_i ? ~addr_instr : ~rd_mapped);

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i && pipe_empty) begin
            if (addr_retired) begin
                prdata_o = retired_i;
            end else if (addr_reg) begin
                prdata_o = host_data_i;
            end
        end
    end

    // the instruction write completes on this edge since pready is high
    assign instr_wr = access & pwrite_i & addr_instr;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_valid_q <= 1'b0;
            issue_cnt_q   <= '0;
        end else begin
            instr_valid_q <= instr_wr;
            if (instr_wr) begin
                issue_cnt_q <= issue_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr) begin
            instr_q <= pwdata_i;
        end
    end

    assign instr_valid_o = instr_valid_q;
    assign instr_o       = instr_q;

endmodule

//--- verilog/decode_issue.sv
// decode_issue module: field and control decode, operand read, decode/execute register
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module decode_issue (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      instr_valid_i,
    input  logic [`MIPS_DATA_W-1:0]   instr_i,
    output logic [`MIPS_REG_W-1:0]    rs_idx_o,
    output logic [`MIPS_REG_W-1:0]    rt_idx_o,
    input  logic [`MIPS_DATA_W-1:0]   rs_data_i,
    input  logic [`MIPS_DATA_W-1:0]   rt_data_i,
    ex_if.dec                         ex
);

    logic [5:0]                   op;
    logic [5:0]                   funct;
    logic [4:0]                   shamt;
    logic [`MIPS_REG_W-1:0]       rd;
    logic [15:0]                  imm;
    logic [`MIPS_DATA_W-1:0]      imm_sext;
    logic [`MIPS_DATA_W-1:0]      imm_zext;
    mips_lite_pkg::alu_op_e       alu_op_d;
    logic [`MIPS_DATA_W-1:0]      opb_d;
    logic [`MIPS_REG_W-1:0]       dst_d;
    logic                         known_d;

    // instruction fields
    assign op       = instr_i[31:26];
    assign rs_idx_o = instr_i[25:21];
    assign rt_idx_o = instr_i[20:16];
    assign rd       = instr_i[15:11];
    assign shamt    = instr_i[10:6];
    assign funct    = instr_i[5:0];
    assign imm      = instr_i[15:0];

    assign imm_sext = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign imm_zext = {{(`MIPS_DATA_W-16){1'b0}}, imm};

    // I-type writes rt, R-type writes rd
    always_comb begin
        alu_op_d = mips_lite_pkg::ALU_NOP;
        opb_d    = imm_zext;
        dst_d    = rt_idx_o;
        known_d  = 1'b1;
        case (op)
            mips_lite_pkg::SPECIAL: begin
                opb_d = rt_data_i;
                dst_d = rd;
                case (funct)
                    mips_lite_pkg::SLL:  alu_op_d = mips_lite_pkg::ALU_SLL;
                    mips_lite_pkg::SRL:  alu_op_d = mips_lite_pkg::ALU_SRL;
                    mips_lite_pkg::ADDU: alu_op_d = mips_lite_pkg::ALU_ADD;
                    mips_lite_pkg::SUBU: alu_op_d = mips_lite_pkg::ALU_SUB;
                    mips_lite_pkg::AND:  alu_op_d = mips_lite_pkg::ALU_AND;
                    mips_lite_pkg::OR:   alu_op_d = mips_lite_pkg::ALU_OR;
                    mips_lite_pkg::XOR:  alu_op_d = mips_lite_pkg::ALU_XOR;
                    mips_lite_pkg::NOR:  alu_op_d = mips_lite_pkg::ALU_NOR;
                    mips_lite_pkg::SLT:  alu_op_d = mips_lite_pkg::ALU_SLT;
                    default:             known_d  = 1'b0;
                endcase
            end
            mips_lite_pkg::ADDIU: begin
                alu_op_d = mips_lite_pkg::ALU_ADD;
                opb_d    = imm_sext;
            end
            mips_lite_pkg::SLTI: begin
                alu_op_d = mips_lite_pkg::ALU_SLT;
                opb_d    = imm_sext;
            end
            mips_lite_pkg::ANDI: alu_op_d = mips_lite_pkg::ALU_AND;
            mips_lite_pkg::ORI:  alu_op_d = mips_lite_pkg::ALU_OR;
            mips_lite_pkg::XORI: alu_op_d = mips_lite_pkg::ALU_XOR;
            mips_lite_pkg::LUI:  alu_op_d = mips_lite_pkg::ALU_LUI;
            default:             known_d  = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex.valid <= 1'b0;
            ex.wr_en <= 1'b0;
        end else begin
            ex.valid <= instr_valid_i;
            // unknown codes still retire but never touch the register file
            ex.wr_en <= instr_valid_i & known_d & (dst_d != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            ex.alu_op <= alu_op_d;
            ex.opa    <= rs_data_i;
            ex.opb    <= opb_d;
            ex.shamt  <= shamt;
            ex.rd     <= dst_d;
        end
    end

endmodule

//--- verilog/ex_if.sv
// ex_if interface carrying one decoded instruction from decode to execute
`timescale 1ns/1ps
`include "mips_lite_config.svh"

interface ex_if;

    logic                         valid;
    mips_lite_pkg::alu_op_e       alu_op;
    logic [`MIPS_DATA_W-1:0]      opa;
    logic [`MIPS_DATA_W-1:0]      opb;
    logic [4:0]                   shamt;
    logic [`MIPS_REG_W-1:0]       rd;
    logic                         wr_en;

    // decode owns the pipeline register, execute only consumes it
    modport dec (output valid, alu_op, opa, opb, shamt, rd, wr_en);
    modport ex  (input  valid, alu_op, opa, opb, shamt, rd, wr_en);

endinterface

//--- verilog/execute_stage.sv
// execute_stage module: ALU, write-back register and retire counter
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module execute_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    ex_if.ex                          ex,
    output logic                      wb_en_o,
    output logic [`MIPS_REG_W-1:0]    wb_rd_o,
    output logic [`MIPS_DATA_W-1:0]   wb_data_o,
    output logic [`MIPS_DATA_W-1:0]   retired_o
);

    logic [`MIPS_DATA_W-1:0] alu_res;
    logic                    slt_bit;
    logic                    wb_valid_q;
    logic                    wb_en_q;
    logic [`MIPS_REG_W-1:0]  wb_rd_q;
    logic [`MIPS_DATA_W-1:0] wb_data_q;
    logic [`MIPS_DATA_W-1:0] retired_q;

    assign slt_bit = ($signed(ex.opa) < $signed(ex.opb));

    // shifts operate on rt, which decode puts in opb
    always_comb begin
        case (ex.alu_op)
            mips_lite_pkg::ALU_ADD: alu_res = ex.opa + ex.opb;
            mips_lite_pkg::ALU_SUB: alu_res = ex.opa - ex.opb;
            mips_lite_pkg::ALU_AND: alu_res = ex.opa & ex.opb;
            mips_lite_pkg::ALU_OR:  alu_res = ex.opa | ex.opb;
            mips_lite_pkg::ALU_XOR: alu_res = ex.opa ^ ex.opb;
            mips_lite_pkg::ALU_NOR: alu_res = ~(ex.opa | ex.opb);
            mips_lite_pkg::ALU_SLT: alu_res = {{(`MIPS_DATA_W-1){1'b0}}, slt_bit};
            mips_lite_pkg::ALU_SLL: alu_res = ex.opb << ex.shamt;
            mips_lite_pkg::ALU_SRL: alu_res = ex.opb >> ex.shamt;
            mips_lite_pkg::ALU_LUI: alu_res = {ex.opb[15:0], 16'h0000};
            default:                alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q <= 1'b0;
            wb_en_q    <= 1'b0;
            retired_q  <= '0;
        end else begin
            wb_valid_q <= ex.valid;
            wb_en_q    <= ex.valid & ex.wr_en;
            // no-ops count too, the register file write lands on this same edge
            if (wb_valid_q) begin
                retired_q <= retired_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb_rd_q   <= ex.rd;
            wb_data_q <= alu_res;
        end
    end

    assign wb_en_o   = wb_en_q;
    assign wb_rd_o   = wb_rd_q;
    assign wb_data_o = wb_data_q;
    assign retired_o = retired_q;

endmodule

//--- verilog/mips_lite_config.svh
// width macros and APB address map for the mips_lite pipeline
`ifndef MIPS_LITE_CONFIG_SVH
`define MIPS_LITE_CONFIG_SVH

// data path and instruction word width
`define MIPS_DATA_W 32

// register index width and register count
`define MIPS_REG_W 5
`define MIPS_NUM_REGS 32

// APB slave address width
`define MIPS_APB_ADDR_W 12

// write-only instruction port
`define MIPS_ADDR_INSTR 12'h000

// read-only retired instruction count
`define MIPS_ADDR_RETIRED 12'h004

// general register n is read at this base plus 4*n
`define MIPS_ADDR_REG_BASE 12'h080

`endif

//--- verilog/mips_lite_pkg.sv
// opcode, funct and ALU operation enums for mips_lite
package mips_lite_pkg;

    // primary opcodes, MIPS encodings
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDIU   = 6'h09,
        SLTI    = 6'h0A,
        ANDI    = 6'h0C,
        ORI     = 6'h0D,
        XORI    = 6'h0E,
        LUI     = 6'h0F
    } opcode_e;

    // funct field of SPECIAL instructions
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2A
    } funct_e;

    // operations carried from decode to the execute ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_LUI = 4'd9,
        ALU_NOP = 4'd15
    } alu_op_e;

endpackage

//--- verilog/mips_lite_top.sv
// mips_lite_top module: APB port, decode, register file and execute joined together
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module mips_lite_top (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [`MIPS_APB_ADDR_W-1:0]   paddr_i,
    input  logic [`MIPS_DATA_W-1:0]       pwdata_i,
    output logic [`MIPS_DATA_W-1:0]       prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o
);

    logic                      instr_valid;
    logic [`MIPS_DATA_W-1:0]   instr;
    logic [`MIPS_REG_W-1:0]    rs_idx;
    logic [`MIPS_REG_W-1:0]    rt_idx;
    logic [`MIPS_DATA_W-1:0]   rs_data;
    logic [`MIPS_DATA_W-1:0]   rt_data;
    logic [`MIPS_REG_W-1:0]    host_idx;
    logic [`MIPS_DATA_W-1:0]   host_data;
    logic                      wb_en;
    logic [`MIPS_REG_W-1:0]    wb_rd;
    logic [`MIPS_DATA_W-1:0]   wb_data;
    logic [`MIPS_DATA_W-1:0]   retired;

    ex_if ex_bus ();

    apb_instr_port u_apb_instr_port (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .instr_valid_o (instr_valid),
        .instr_o       (instr),
        .retired_i     (retired),
        .host_idx_o    (host_idx),
        .host_data_i   (host_data)
    );

    decode_issue u_decode_issue (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .rs_idx_o      (rs_idx),
        .rt_idx_o      (rt_idx),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .ex            (ex_bus.dec)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rs_idx_i    (rs_idx),
        .rt_idx_i    (rt_idx),
        .host_idx_i  (host_idx),
        .rs_data_o   (rs_data),
        .rt_data_o   (rt_data),
        .host_data_o (host_data),
        .wb_en_i     (wb_en),
        .wb_rd_i     (wb_rd),
        .wb_data_i   (wb_data)
    );

    execute_stage u_execute_stage (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ex        (ex_bus.ex),
        .wb_en_o   (wb_en),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data),
        .retired_o (retired)
    );

endmodule

//--- verilog/reg_file.sv
// reg_file module: 31 general registers, two decode read ports, host read port
`timescale 1ns/1ps
`include "mips_lite_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`MIPS_REG_W-1:0]    rs_idx_i,
    input  logic [`MIPS_REG_W-1:0]    rt_idx_i,
    input  logic [`MIPS_REG_W-1:0]    host_idx_i,
    output logic [`MIPS_DATA_W-1:0]   rs_data_o,
    output logic [`MIPS_DATA_W-1:0]   rt_data_o,
    output logic [`MIPS_DATA_W-1:0]   host_data_o,
    input  logic                      wb_en_i,
    input  logic [`MIPS_REG_W-1:0]    wb_rd_i,
    input  logic [`MIPS_DATA_W-1:0]   wb_data_i
);

    // register 0 has no storage
    logic [`MIPS_DATA_W-1:0] regs [1:`MIPS_NUM_REGS-1];
    logic                    wr_live;

    assign wr_live = wb_en_i & (wb_rd_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // decode ports see a same-cycle write so a dependent instruction needs no stall
    assign rs_data_o = (rs_idx_i == '0) ? '0 :
                       (wr_live && (wb_rd_i == rs_idx_i)) ? wb_data_i : regs[rs_idx_i];
    assign rt_data_o = (rt_idx_i == '0) ? '0 :
                       (wr_live && (wb_rd_i == rt_idx_i)) ? wb_data_i : regs[rt_idx_i];

    // host reads only happen with the pipeline empty
    assign host_data_o = (host_idx_i == '0) ? '0 : regs[host_idx_i];

endmodule
